// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_nes_host
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert -sv --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert -sv --timescale 1ns/1ps
PASS_TEXT  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   lint, build and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@if ./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_TEXT)' > /dev/null; \
	then echo "simulation passed"; else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
hw/host_cmd_pkg.sv
hw/nes_mem_pkg.sv
hw/host_cmd_regs.sv
hw/joypad_serializer.sv
hw/ce_sequencer.sv
hw/mem_request_arbiter.sv
hw/nes_host_top.sv
verif/tb_nes_host.sv

// ==== hw/ce_sequencer.sv ====
/*
 * Clock-enable sequencer. A free-running phase counter lets the memory run on
 * phase 0 and the console on the last phase of each period. Both enables stay
 * off, and the console stays in reset, until the ROM loader reports done.
 */
module ce_sequencer #(
  parameter int CE_PERIOD = 6  // clocks per console cycle, 2 to 16
) (
  input  logic clk,
  input  logic reset,
  input  logic loader_done,
  output logic reset_nes,
  output logic run_mem,
  output logic run_nes
);

  localparam nes_mem_pkg::ce_phase_e LAST_PHASE = nes_mem_pkg::ce_phase_e'(CE_PERIOD - 1);

  nes_mem_pkg::ce_phase_e phase;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= nes_mem_pkg::PH_MEM_RUN;
    end else if (phase == LAST_PHASE) begin
      phase <= nes_mem_pkg::PH_MEM_RUN;  // wrap
    end else begin
      phase <= nes_mem_pkg::ce_phase_e'(phase + 4'd1);
    end
  end

  assign reset_nes = !loader_done;

  // memory gets its slot first
  assign run_mem = (phase == nes_mem_pkg::PH_MEM_RUN) && loader_done;
  // read data is back by now
  assign run_nes = (phase == LAST_PHASE) && loader_done;

  // memory and console slots never overlap
  a_slots_apart: assert property (
    @(posedge clk) disable iff (reset) !(run_mem && run_nes)
  ) else $error("run_mem and run_nes high in the same cycle");

endmodule

// ==== hw/host_cmd_pkg.sv ====
/*
 * Host command definitions shared by the command register file and the top level.
 * Addresses match the byte codes the UART demultiplexer hands over.
 */
package host_cmd_pkg;

  typedef logic [7:0] host_byte_t;  // one byte from the host link

  // command address byte, one value per register or data port
  typedef enum logic [7:0] {
    CMD_LOADER_CONF  = 8'h35,
    CMD_ROM_DATA     = 8'h37,  // streamed into the ROM loader
    CMD_PAD0_BUTTONS = 8'h40,
    CMD_PAD1_BUTTONS = 8'h41,
    CMD_OSD_ADDR_LO  = 8'h80,
    CMD_OSD_ADDR_HI  = 8'h81,
    CMD_OSD_DATA     = 8'h82,  // auto-increments the OSD address
    CMD_OSD_ENABLE   = 8'h83
  } cmd_addr_e;

  localparam int OSD_ADDR_W = 12;  // 4K character cells
  typedef logic [OSD_ADDR_W-1:0] osd_addr_t;

  localparam int NUM_PADS = 2;  // controller ports on the console

endpackage

// ==== hw/host_cmd_regs.sv ====
/*
 * Host command register file. Decodes address/data/strobe triples from the
 * host link into loader, controller and OSD state. ROM and OSD data bytes
 * are not stored here and leave in the same cycle with their strobes.
 */
module host_cmd_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  host_cmd_pkg::cmd_addr_e  cmd_addr,
  input  host_cmd_pkg::host_byte_t cmd_data,
  input  logic                     cmd_write,
  output host_cmd_pkg::host_byte_t buttons [host_cmd_pkg::NUM_PADS],
  output logic                     loader_reset,
  output host_cmd_pkg::host_byte_t loader_byte,
  output logic                     loader_byte_valid,
  output logic                     osd_enable,
  output host_cmd_pkg::osd_addr_t  osd_addr,
  output host_cmd_pkg::host_byte_t osd_din,
  output logic                     osd_we
);

  localparam int OSD_HI_W = host_cmd_pkg::OSD_ADDR_W - 8;  // bits held in the high write

  // register writes, visible the cycle after the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < host_cmd_pkg::NUM_PADS; i++) begin
        buttons[i] <= '0;
      end
      loader_reset <= 1'b0;
      osd_enable   <= 1'b0;
      osd_addr     <= '0;
    end else if (cmd_write) begin
      case (cmd_addr)
        host_cmd_pkg::CMD_LOADER_CONF:  loader_reset <= cmd_data[0];  // only bit 0 is defined
        host_cmd_pkg::CMD_PAD0_BUTTONS: buttons[0]   <= cmd_data;
        host_cmd_pkg::CMD_PAD1_BUTTONS: buttons[1]   <= cmd_data;
        host_cmd_pkg::CMD_OSD_ADDR_LO:  osd_addr[7:0] <= cmd_data;
        host_cmd_pkg::CMD_OSD_ADDR_HI: begin
          osd_addr[host_cmd_pkg::OSD_ADDR_W-1:8] <= cmd_data[OSD_HI_W-1:0];
        end
        host_cmd_pkg::CMD_OSD_DATA: begin
          osd_addr <= osd_addr + host_cmd_pkg::osd_addr_t'(1);  // next cell
        end
        host_cmd_pkg::CMD_OSD_ENABLE:   osd_enable <= cmd_data[0];
        default: ;  // ROM data and unknown codes hold state
      endcase
    end
  end

  // pass-through ports, same cycle as the strobe
  always_comb begin
    loader_byte       = cmd_data;
    loader_byte_valid = cmd_write && (cmd_addr == host_cmd_pkg::CMD_ROM_DATA);
    osd_din           = cmd_data;
    osd_we            = cmd_write && (cmd_addr == host_cmd_pkg::CMD_OSD_DATA);
  end

  // a single host byte must never reach both the loader and the OSD
  a_one_data_sink: assert property (
    @(posedge clk) disable iff (reset) !(osd_we && loader_byte_valid)
  ) else $error("host byte strobed into loader and OSD at once");

endmodule

// ==== hw/joypad_serializer.sv ====
/*
 * One controller port. Latches the button byte while the console holds the
 * strobe and shifts it out LSB first on each falling edge of the pad clock.
 */
module joypad_serializer (
  input  logic                     clk,
  input  logic                     reset,
  input  host_cmd_pkg::host_byte_t buttons,
  input  logic                     strobe,
  input  logic                     pad_clock,
  output logic                     pad_data
);

  host_cmd_pkg::host_byte_t shift_q;
  logic                     pad_clock_q;  // previous pad clock sample
  logic                     pad_clock_fall;

  assign pad_clock_fall = pad_clock_q && !pad_clock;

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q     <= '0;
      pad_clock_q <= 1'b0;  // no edge seen out of reset
    end else begin
      pad_clock_q <= pad_clock;
      if (strobe) begin
        shift_q <= buttons;  // parallel load while strobe held
      end else if (pad_clock_fall) begin
        shift_q <= {1'b0, shift_q[7:1]};  // zeros follow the last button
      end
    end
  end

  // console reads bit 0, A button first after a load
  assign pad_data = shift_q[0];

endmodule

// ==== hw/mem_request_arbiter.sv ====
/*
 * Memory request arbiter. Loader writes win outright; console requests go
 * through only in the memory slot. Refresh fills idle memory slots once the
 * game is loaded, and follows the loader before that.
 */
module mem_request_arbiter (
  input  logic                  run_mem,
  input  logic                  loader_done,
  input  logic                  loader_write,
  input  logic                  loader_refresh,
  input  nes_mem_pkg::mem_addr_t loader_addr,
  input  nes_mem_pkg::mem_data_t loader_data,
  input  logic                  nes_read_cpu,
  input  logic                  nes_read_ppu,
  input  logic                  nes_write,
  input  nes_mem_pkg::mem_addr_t nes_addr,
  input  nes_mem_pkg::mem_data_t nes_wdata,
  output logic                  mem_read_a,
  output logic                  mem_read_b,
  output logic                  mem_write,
  output logic                  mem_refresh,
  output nes_mem_pkg::mem_addr_t mem_addr,
  output nes_mem_pkg::mem_data_t mem_din
);

  logic nes_req;   // console wants memory this period
  logic nes_slot;  // console may use the memory now

  always_comb begin
    nes_req  = nes_read_cpu || nes_read_ppu || nes_write;
    nes_slot = run_mem && loader_done && !loader_write;

    mem_read_a = nes_slot && nes_read_cpu;  // cpu port
    mem_read_b = nes_slot && nes_read_ppu;  // ppu port
    mem_write  = loader_write || (nes_slot && nes_write);
    mem_addr   = loader_write ? loader_addr : nes_addr;
    mem_din    = loader_write ? loader_data : nes_wdata;

    if (loader_write) begin
      mem_refresh = 1'b0;
    end else if (loader_done) begin
      mem_refresh = run_mem && !nes_req;  // idle memory slot
    end else begin
      mem_refresh = loader_refresh;
    end

    // refresh must own the memory for the whole slot
    a_refresh_alone: assert (!(mem_refresh && (mem_write || mem_read_a || mem_read_b)))
      else $error("refresh issued together with a memory access");
  end

endmodule

// ==== hw/nes_host_top.sv ====
/*
 * Host side of the console core. Connects the command register file, the
 * controller serializers, the clock-enable sequencer and the memory arbiter.
 * The console core and the ROM loader attach through the ports below.
 */
module nes_host_top #(
  parameter int CE_PERIOD = 6
) (
  input  logic                                 clk,
  input  logic                                 reset,
  // host command bus
  input  host_cmd_pkg::cmd_addr_e              cmd_addr,
  input  host_cmd_pkg::host_byte_t             cmd_data,
  input  logic                                 cmd_write,
  // ROM loader
  output logic                                 loader_reset,
  output host_cmd_pkg::host_byte_t             loader_byte,
  output logic                                 loader_byte_valid,
  input  logic                                 loader_done,
  input  logic                                 loader_write,
  input  logic                                 loader_refresh,
  input  nes_mem_pkg::mem_addr_t               loader_addr,
  input  nes_mem_pkg::mem_data_t               loader_data,
  // OSD
  output logic                                 osd_enable,
  output host_cmd_pkg::osd_addr_t              osd_addr,
  output host_cmd_pkg::host_byte_t             osd_din,
  output logic                                 osd_we,
  // console
  input  logic                                 joypad_strobe,
  input  logic [host_cmd_pkg::NUM_PADS-1:0]    joypad_clock,
  output logic [host_cmd_pkg::NUM_PADS-1:0]    joypad_data,
  output logic                                 reset_nes,
  output logic                                 run_mem,
  output logic                                 run_nes,
  input  logic                                 nes_read_cpu,
  input  logic                                 nes_read_ppu,
  input  logic                                 nes_write,
  input  nes_mem_pkg::mem_addr_t               nes_addr,
  input  nes_mem_pkg::mem_data_t               nes_wdata,
  // memory
  output logic                                 mem_read_a,
  output logic                                 mem_read_b,
  output logic                                 mem_write,
  output logic                                 mem_refresh,
  output nes_mem_pkg::mem_addr_t               mem_addr,
  output nes_mem_pkg::mem_data_t               mem_din
);

  host_cmd_pkg::host_byte_t buttons [host_cmd_pkg::NUM_PADS];  // host-set button state

  host_cmd_regs u_cmd_regs (
    .clk, .reset, .cmd_addr, .cmd_data, .cmd_write,
    .buttons, .loader_reset, .loader_byte, .loader_byte_valid,
    .osd_enable, .osd_addr, .osd_din, .osd_we
  );

  for (genvar i = 0; i < host_cmd_pkg::NUM_PADS; i++) begin : g_pad
    joypad_serializer u_pad (
      .clk,
      .reset,
      .buttons   (buttons[i]),
      .strobe    (joypad_strobe),  // shared latch line
      .pad_clock (joypad_clock[i]),
      .pad_data  (joypad_data[i])
    );
  end

  ce_sequencer #(
    .CE_PERIOD (CE_PERIOD)
  ) u_ce_seq (
    .clk, .reset, .loader_done, .reset_nes, .run_mem, .run_nes
  );

  mem_request_arbiter u_arbiter (
    .run_mem, .loader_done, .loader_write, .loader_refresh, .loader_addr, .loader_data,
    .nes_read_cpu, .nes_read_ppu, .nes_write, .nes_addr, .nes_wdata,
    .mem_read_a, .mem_read_b, .mem_write, .mem_refresh, .mem_addr, .mem_din
  );

endmodule

// ==== hw/nes_mem_pkg.sv ====
/*
 * Memory side definitions: address and data types for the shared memory,
 * plus the phase names of the clock-enable sequence.
 */
package nes_mem_pkg;

  localparam int MEM_ADDR_W = 22;  // 4 MB address space
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  typedef logic [7:0] mem_data_t;

  // one console period, memory runs first and the console last
  //   0 run_mem, 1 mem cmd issued, 2..3 read latency, 4 data out, 5 run_nes
  typedef enum logic [3:0] {
    PH_MEM_RUN = 4'd0,
    PH_MEM_CMD = 4'd1,
    PH_WAIT_2  = 4'd2,
    PH_WAIT_3  = 4'd3,
    PH_DOUT    = 4'd4,
    PH_NES_RUN = 4'd5
  } ce_phase_e;

endpackage

// ==== verif/tb_nes_host.sv ====
/*
 * Directed testbench for the console host side. Runs command register,
 * controller, enable cadence and memory arbitration tests in sequence.
 */
module tb_nes_host;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CE_PERIOD    = 6;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 64;  // cycles before a wait gives up

  logic clk, reset;
  host_cmd_pkg::cmd_addr_e cmd_addr;
  host_cmd_pkg::host_byte_t cmd_data, loader_byte, osd_din;
  logic cmd_write, loader_reset, loader_byte_valid, osd_enable, osd_we;
  host_cmd_pkg::osd_addr_t osd_addr;
  logic loader_done, loader_write, loader_refresh;
  nes_mem_pkg::mem_addr_t loader_addr, nes_addr, mem_addr;
  nes_mem_pkg::mem_data_t loader_data, nes_wdata, mem_din;
  logic joypad_strobe;
  logic [host_cmd_pkg::NUM_PADS-1:0] joypad_clock, joypad_data;
  logic reset_nes, run_mem, run_nes, nes_read_cpu, nes_read_ppu, nes_write;
  logic mem_read_a, mem_read_b, mem_write, mem_refresh;

  int seed = 32'hcc9d9412;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int errors_at_start;
  // strobe outputs seen in the cycle of the last host write
  logic seen_rom_valid, seen_osd_we;
  host_cmd_pkg::host_byte_t seen_rom_byte, seen_osd_din;

  nes_host_top #(.CE_PERIOD(CE_PERIOD)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string what, input host_cmd_pkg::host_byte_t got, exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_osd_addr(input string what, input host_cmd_pkg::osd_addr_t got, exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_mem_addr(input string what, input nes_mem_pkg::mem_addr_t got, exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_mem_data(input string what, input nes_mem_pkg::mem_data_t got, exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic host_cmd_pkg::host_byte_t rand_byte();
    return host_cmd_pkg::host_byte_t'($random(seed));
  endfunction

  // bit the console should read after n falling edges, zeros past the last button
  function automatic logic pad_bit(input host_cmd_pkg::host_byte_t b, input int n);
    host_cmd_pkg::host_byte_t s;
    s = b >> n;
    return s[0];
  endfunction

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_at_start);
    end
  endtask

  // one host write, strobes captured mid-cycle, registers settled on return
  task automatic send_cmd(input host_cmd_pkg::cmd_addr_e addr,
                          input host_cmd_pkg::host_byte_t data);
    @(posedge clk);
    cmd_addr  <= addr;
    cmd_data  <= data;
    cmd_write <= 1'b1;
    @(negedge clk);
    seen_rom_valid = loader_byte_valid;
    seen_rom_byte  = loader_byte;
    seen_osd_we    = osd_we;
    seen_osd_din   = osd_din;
    @(posedge clk);
    cmd_write <= 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_pad_clock(input bit pad);
    @(posedge clk);
    joypad_clock[pad] <= 1'b0;
    @(posedge clk);
    joypad_clock[pad] <= 1'b1;  // low level sampled on this edge
    @(negedge clk);
  endtask

  // counts cycles until run_mem, or run_nes when console is set
  task automatic wait_enable(input bit console, output int cycles);
    logic seen;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      seen = console ? run_nes : run_mem;
    end
    if (!seen) begin
      $display("timeout: %s never went high within %0d cycles",
               console ? "run_nes" : "run_mem", WAIT_LIMIT);
      errors++;
    end
  endtask

  // holds one set of requests for a full period, memory slot comes last
  task automatic arb_period(input logic cpu, input logic ppu, input logic wr, input logic lw);
    nes_mem_pkg::mem_addr_t naddr, laddr;
    nes_mem_pkg::mem_data_t ndata, ldata;
    int n;
    logic slot;
    naddr = nes_mem_pkg::mem_addr_t'($random(seed));
    laddr = nes_mem_pkg::mem_addr_t'($random(seed));
    ndata = nes_mem_pkg::mem_data_t'($random(seed));
    ldata = nes_mem_pkg::mem_data_t'($random(seed));
    wait_enable(1'b0, n);
    @(posedge clk);
    nes_read_cpu <= cpu;
    nes_read_ppu <= ppu;
    nes_write    <= wr;
    nes_addr     <= naddr;
    nes_wdata    <= ndata;
    loader_write <= lw;
    loader_addr  <= laddr;
    loader_data  <= ldata;
    for (int k = 1; k <= CE_PERIOD; k++) begin
      @(negedge clk);
      slot = (k == CE_PERIOD);
      check_bit($sformatf("mem_read_a cycle %0d", k), mem_read_a, slot && cpu && !lw);
      check_bit($sformatf("mem_read_b cycle %0d", k), mem_read_b, slot && ppu && !lw);
      check_bit($sformatf("mem_write cycle %0d", k), mem_write, lw || (slot && wr));
      check_bit($sformatf("mem_refresh cycle %0d", k), mem_refresh,
                slot && !lw && !(cpu || ppu || wr));
      if (lw) begin
        check_mem_addr("loader address", mem_addr, laddr);
        check_mem_data("loader data", mem_din, ldata);
      end else if (slot && (cpu || ppu || wr)) begin
        check_mem_addr("console address", mem_addr, naddr);
        if (wr) check_mem_data("console data", mem_din, ndata);
      end
    end
    @(posedge clk);
    {nes_read_cpu, nes_read_ppu, nes_write, loader_write} <= 4'b0000;
  endtask

  task automatic test_cmd_regs();
    host_cmd_pkg::host_byte_t lo, hi, d;
    host_cmd_pkg::osd_addr_t exp_addr;
    errors_at_start = errors;
    check_bit("osd_enable after reset", osd_enable, 1'b0);
    check_bit("loader_reset after reset", loader_reset, 1'b0);
    lo = rand_byte();
    hi = rand_byte();
    send_cmd(host_cmd_pkg::CMD_OSD_ADDR_LO, lo);
    send_cmd(host_cmd_pkg::CMD_OSD_ADDR_HI, hi);
    exp_addr = host_cmd_pkg::osd_addr_t'({hi, lo});  // upper bits drop off
    check_osd_addr("composed osd_addr", osd_addr, exp_addr);
    for (int j = 0; j < 3; j++) begin
      d = rand_byte();
      send_cmd(host_cmd_pkg::CMD_OSD_DATA, d);
      check_bit("osd_we on data write", seen_osd_we, 1'b1);
      check_byte("osd_din", seen_osd_din, d);
      check_bit("loader_byte_valid on osd write", seen_rom_valid, 1'b0);
      exp_addr = exp_addr + host_cmd_pkg::osd_addr_t'(1);
      check_osd_addr("osd_addr after data", osd_addr, exp_addr);
    end
    send_cmd(host_cmd_pkg::CMD_OSD_ENABLE, rand_byte() | 8'h01);
    check_bit("osd_enable set", osd_enable, 1'b1);
    send_cmd(host_cmd_pkg::CMD_OSD_ENABLE, rand_byte() & 8'hfe);
    check_bit("osd_enable clear", osd_enable, 1'b0);
    send_cmd(host_cmd_pkg::CMD_LOADER_CONF, 8'h01);
    check_bit("loader_reset set", loader_reset, 1'b1);
    send_cmd(host_cmd_pkg::CMD_LOADER_CONF, 8'h00);
    check_bit("loader_reset clear", loader_reset, 1'b0);
    finish_test("command registers");
  endtask

  task automatic test_rom_bytes();
    host_cmd_pkg::host_byte_t d;
    errors_at_start = errors;
    d = rand_byte();
    send_cmd(host_cmd_pkg::CMD_ROM_DATA, d);
    check_bit("loader_byte_valid on rom write", seen_rom_valid, 1'b1);
    check_byte("loader_byte", seen_rom_byte, d);
    check_bit("osd_we on rom write", seen_osd_we, 1'b0);
    check_bit("loader_byte_valid after strobe", loader_byte_valid, 1'b0);
    send_cmd(host_cmd_pkg::CMD_PAD1_BUTTONS, rand_byte());
    check_bit("loader_byte_valid on pad write", seen_rom_valid, 1'b0);
    send_cmd(host_cmd_pkg::CMD_OSD_ADDR_LO, rand_byte());
    check_bit("loader_byte_valid on osd addr write", seen_rom_valid, 1'b0);
    send_cmd(host_cmd_pkg::CMD_LOADER_CONF, 8'h00);
    check_bit("loader_byte_valid on conf write", seen_rom_valid, 1'b0);
    finish_test("rom pass-through");
  endtask

  task automatic test_joypads();
    host_cmd_pkg::host_byte_t b0, b1;
    errors_at_start = errors;
    b0 = rand_byte();
    b1 = rand_byte();
    send_cmd(host_cmd_pkg::CMD_PAD0_BUTTONS, b0);
    send_cmd(host_cmd_pkg::CMD_PAD1_BUTTONS, b1);
    @(posedge clk);
    joypad_strobe <= 1'b1;
    @(posedge clk);
    joypad_strobe <= 1'b0;
    @(negedge clk);
    check_bit("pad 0 first bit", joypad_data[0], pad_bit(b0, 0));
    check_bit("pad 1 first bit", joypad_data[1], pad_bit(b1, 0));
    // pads stepped in turn, the idle one must hold
    for (int k = 1; k <= 9; k++) begin
      pulse_pad_clock(1'b0);
      check_bit($sformatf("pad 0 bit %0d", k), joypad_data[0], pad_bit(b0, k));
      check_bit($sformatf("pad 1 held at %0d", k - 1), joypad_data[1], pad_bit(b1, k - 1));
      pulse_pad_clock(1'b1);
      check_bit($sformatf("pad 1 bit %0d", k), joypad_data[1], pad_bit(b1, k));
    end
    finish_test("controller serialization");
  endtask

  task automatic test_cadence();
    nes_mem_pkg::ce_phase_e nes_phase;
    int n_nes, n_mem;
    errors_at_start = errors;
    nes_phase = nes_mem_pkg::ce_phase_e'(CE_PERIOD - 1);
    for (int k = 0; k < 2 * CE_PERIOD; k++) begin
      @(negedge clk);
      check_bit("run_mem while loading", run_mem, 1'b0);
      check_bit("run_nes while loading", run_nes, 1'b0);
      check_bit("reset_nes while loading", reset_nes, 1'b1);
    end
    @(posedge clk);
    loader_done <= 1'b1;
    wait_enable(1'b0, n_mem);
    for (int p = 0; p < 10; p++) begin
      check_bit("reset_nes after load", reset_nes, 1'b0);
      wait_enable(1'b1, n_nes);
      check_bit($sformatf("run_nes %0d cycles after run_mem, expected phase %s",
                          n_nes, nes_phase.name()), n_nes == CE_PERIOD - 1, 1'b1);
      wait_enable(1'b0, n_mem);
      check_bit($sformatf("run_mem period %0d cycles", n_nes + n_mem),
                n_nes + n_mem == CE_PERIOD, 1'b1);
    end
    finish_test("enable cadence");
  endtask

  task automatic test_arbitration();
    errors_at_start = errors;
    arb_period(1'b1, 1'b1, 1'b1, 1'b1);  // loader against every console request
    arb_period(1'b1, 1'b0, 1'b0, 1'b0);
    arb_period(1'b0, 1'b1, 1'b0, 1'b0);
    arb_period(1'b0, 1'b0, 1'b1, 1'b0);
    finish_test("arbitration");
  endtask

  task automatic test_refresh();
    logic r;
    errors_at_start = errors;
    @(posedge clk);
    loader_done <= 1'b0;
    for (int k = 0; k < 2 * CE_PERIOD; k++) begin
      @(posedge clk);
      r = 1'($random(seed));
      loader_refresh <= r;
      @(negedge clk);
      check_bit("mem_refresh follows loader", mem_refresh, r);
    end
    @(posedge clk);
    loader_done    <= 1'b1;
    loader_refresh <= 1'b1;  // ignored once loaded
    arb_period(1'b0, 1'b0, 1'b0, 1'b0);
    arb_period(1'b0, 1'b1, 1'b0, 1'b0);
    loader_refresh <= 1'b0;
    finish_test("refresh");
  endtask

  initial begin
    reset          <= 1'b1;
    cmd_addr       <= host_cmd_pkg::CMD_LOADER_CONF;
    cmd_data       <= '0;
    cmd_write      <= 1'b0;
    loader_done    <= 1'b0;
    loader_write   <= 1'b0;
    loader_refresh <= 1'b0;
    loader_addr    <= '0;
    loader_data    <= '0;
    joypad_strobe  <= 1'b0;
    joypad_clock   <= '1;  // pad clock idles high
    nes_read_cpu   <= 1'b0;
    nes_read_ppu   <= 1'b0;
    nes_write      <= 1'b0;
    nes_addr       <= '0;
    nes_wdata      <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_cmd_regs();
    test_rom_bytes();
    test_joypads();
    test_cadence();
    test_arbitration();
    test_refresh();
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
